// File: filelist.f
design/ecc_pkg.sv
design/key_register.sv
design/point_registers.sv
design/micro_op_table.sv
design/point_sequencer.sv
design/point_mult_top.sv
test/field_unit_model.sv
test/point_mult_assertions.sv
test/point_mult_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the point multiplier testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module point_mult_tb -f filelist.f -o point_mult_sim

status=0
./obj_dir/point_mult_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"

// File: test/point_mult_tb.sv
`timescale 1ns/1ps

module point_mult_tb;

    localparam int     KEY_BITS = ecc_pkg::KEY_BITS_DEFAULT;
    localparam int     NUM_VEC  = 4;
    localparam int     BUSY_VEC = 2;    // gets a second start while busy
    localparam int     TIMEOUT  = NUM_VEC * 21 * KEY_BITS * 10;
    localparam longint PRIME    = 64'd2147483647;

    logic                i_clk = 1'b0;
    logic                i_reset;
    logic                i_start;
    logic [KEY_BITS-1:0] i_key;
    ecc_pkg::field_t     i_px;
    ecc_pkg::field_t     i_py;
    ecc_pkg::field_t     i_a;
    ecc_pkg::field_op_t  o_op;
    ecc_pkg::field_t     o_opnd_a;
    ecc_pkg::field_t     o_opnd_b;
    logic                o_op_req;
    logic                i_op_done;
    ecc_pkg::field_t     i_op_result;
    logic                o_busy;
    logic                o_done;
    ecc_pkg::field_t     o_qx;
    ecc_pkg::field_t     o_qy;

    ecc_pkg::field_t     vec_px  [NUM_VEC];
    ecc_pkg::field_t     vec_py  [NUM_VEC];
    ecc_pkg::field_t     vec_a   [NUM_VEC];
    logic [KEY_BITS-1:0] vec_key [NUM_VEC];
    ecc_pkg::field_t     exp_qx  [NUM_VEC];
    ecc_pkg::field_t     exp_qy  [NUM_VEC];

    int   errors    = 0;
    int   checks    = 0;
    int   cycles    = 0;
    int   req_count = 0;
    logic req_q     = 1'b0;

    always #5 i_clk = ~i_clk;

    point_mult_top #(
        .FIELD_WIDTH (ecc_pkg::FIELD_WIDTH_DEFAULT),
        .KEY_BITS    (KEY_BITS)
    ) uut (.*);

    field_unit_model field_unit (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_req    (o_op_req),
        .i_op     (o_op),
        .i_opnd_a (o_opnd_a),
        .i_opnd_b (o_opnd_b),
        .o_done   (i_op_done),
        .o_result (i_op_result)
    );

    // rising edges of the request, DUT only moves at posedge
    always @(negedge i_clk)
    begin
        if (o_op_req && !req_q)
            req_count++;
        req_q = o_op_req;
    end

    function automatic longint add_mod(input longint x, input longint y);
        return (x + y) % PRIME;
    endfunction

    function automatic longint sub_mod(input longint x, input longint y);
        return (x - y + PRIME) % PRIME;
    endfunction

    function automatic longint mul_mod(input longint x, input longint y);
        return (x * y) % PRIME;
    endfunction

    function automatic longint inverse(input longint x);
        longint r;
        longint b;
        longint e;
        r = 1;
        b = x;
        e = PRIME - 2;
        while (e > 0)
        begin
            if (e % 2 == 1)
                r = mul_mod(r, b);
            b = mul_mod(b, b);
            e = e / 2;
        end
        return r;
    endfunction

    task automatic double_point(inout longint x, inout longint y, input longint a);
        longint l;
        longint nx;
        l  = mul_mod(add_mod(mul_mod(3, mul_mod(x, x)), a), inverse(add_mod(y, y)));
        nx = sub_mod(mul_mod(l, l), add_mod(x, x));
        y  = sub_mod(mul_mod(l, sub_mod(x, nx)), y);
        x  = nx;
    endtask

    task automatic add_base(inout longint x, inout longint y, input longint bx, input longint by);
        longint l;
        longint nx;
        l  = mul_mod(sub_mod(by, y), inverse(sub_mod(bx, x)));
        nx = sub_mod(sub_mod(mul_mod(l, l), x), bx);
        y  = sub_mod(mul_mod(l, sub_mod(x, nx)), y);
        x  = nx;
    endtask

    // table entry plus its expected (2^K + key)P
    task automatic set_vector(input int v, input ecc_pkg::field_t px, input ecc_pkg::field_t py,
                              input ecc_pkg::field_t a, input logic [KEY_BITS-1:0] key);
        longint x;
        longint y;
        vec_px[v]  = px;
        vec_py[v]  = py;
        vec_a[v]   = a;
        vec_key[v] = key;
        x = {32'd0, px};
        y = {32'd0, py};
        for (int i = KEY_BITS - 1; i >= 0; i--)
        begin
            double_point(x, y, {32'd0, a});
            if (key[i])
                add_base(x, y, {32'd0, px}, {32'd0, py});
        end
        exp_qx[v] = ecc_pkg::field_t'(x);
        exp_qy[v] = ecc_pkg::field_t'(y);
    endtask

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("FAIL %0t: %s", $time, what);
        end
    endtask

    task automatic run_vector(input int v);
        int              start_reqs;
        int              exp_reqs;
        ecc_pkg::field_t qx;
        ecc_pkg::field_t qy;
        exp_reqs   = 12 * KEY_BITS + 9 * $countones(vec_key[v]);
        start_reqs = req_count;
        @(posedge i_clk);
        i_px    <= vec_px[v];
        i_py    <= vec_py[v];
        i_a     <= vec_a[v];
        i_key   <= vec_key[v];
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        @(negedge i_clk);
        check(o_busy, $sformatf("vector %0d busy not high after start", v));
        if (v == BUSY_VEC)
        begin
            repeat (5) @(posedge i_clk);
            i_px    <= vec_px[0];
            i_key   <= ~vec_key[v];
            i_start <= 1'b1;    // must be ignored
            @(posedge i_clk);
            i_start <= 1'b0;
        end
        do
            @(negedge i_clk);
        while (!o_done);
        check(o_qx == exp_qx[v] && o_qy == exp_qy[v],
              $sformatf("vector %0d result %h,%h expected %h,%h",
                        v, o_qx, o_qy, exp_qx[v], exp_qy[v]));
        check(req_count - start_reqs == exp_reqs,
              $sformatf("vector %0d made %0d requests, expected %0d",
                        v, req_count - start_reqs, exp_reqs));
        check(!o_busy, $sformatf("vector %0d busy high with done", v));
        qx = o_qx;
        qy = o_qy;
        @(negedge i_clk);
        check(!o_done, $sformatf("vector %0d done longer than one cycle", v));
        repeat (3) @(negedge i_clk);
        check(o_qx == qx && o_qy == qy, $sformatf("vector %0d result not held", v));
    endtask

    initial
    begin
        while (cycles < TIMEOUT)
        begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT never finished", cycles);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        i_reset = 1'b1;
        i_start = 1'b0;
        i_key   = '0;
        i_px    = '0;
        i_py    = '0;
        i_a     = '0;
        set_vector(0, 32'h0000_1234, 32'h0000_5678, 32'h0000_0003, 16'h0000);    // doubling only
        set_vector(1, 32'h1a2b_3c4d, 32'h0bad_cafe, 32'h0000_0007, 16'hffff);
        set_vector(2, 32'h7654_3210, 32'h0123_4567, 32'h7fff_fffc, 16'ha5c3);
        set_vector(3, 32'h3141_5926, 32'h2718_2818, 32'h0000_0000, 16'h8001);
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        check(!o_op_req && !o_busy && !o_done, "request, busy or done not low after reset");
        for (int v = 0; v < NUM_VEC; v++)
            run_vector(v);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: test/point_mult_assertions.sv
`timescale 1ns/1ps

module point_mult_assertions (
    input logic               i_clk,
    input logic               i_reset,
    input logic               i_op_req,
    input ecc_pkg::field_op_t i_op,
    input ecc_pkg::field_t    i_opnd_a,
    input ecc_pkg::field_t    i_opnd_b,
    input logic               i_op_done,
    input logic               i_done,
    input logic               i_busy
);

    // request and its operands held until the field unit answers
    hold_request: assert property (@(posedge i_clk) disable iff (i_reset)
        i_op_req && !i_op_done |=> i_op_req && $stable(i_op)
                                   && $stable(i_opnd_a) && $stable(i_opnd_b))
        else $error("request, opcode or operands changed before the field unit answered");

    drop_after_done: assert property (@(posedge i_clk) disable iff (i_reset)
        i_op_done |=> !i_op_req)
        else $error("request still high in the cycle after the field unit answered");

    single_done: assert property (@(posedge i_clk) disable iff (i_reset)
        i_done |=> !i_done)
        else $error("done pulse lasted longer than one cycle");

    idle_at_done: assert property (@(posedge i_clk) disable iff (i_reset)
        i_done |-> !i_busy)
        else $error("busy still high while done is pulsed");

endmodule

bind point_mult_top point_mult_assertions u_assert (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_op_req  (o_op_req),
    .i_op      (o_op),
    .i_opnd_a  (o_opnd_a),
    .i_opnd_b  (o_opnd_b),
    .i_op_done (i_op_done),
    .i_done    (o_done),
    .i_busy    (o_busy)
);

// File: test/field_unit_model.sv
`timescale 1ns/1ps

module field_unit_model #(
    parameter ecc_pkg::field_t PRIME = 32'd2147483647
) (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_req,
    input  ecc_pkg::field_op_t i_op,
    input  ecc_pkg::field_t    i_opnd_a,
    input  ecc_pkg::field_t    i_opnd_b,
    output logic               o_done,
    output ecc_pkg::field_t    o_result
);

    integer          seed     = 32'h61100e7e;
    logic            done_q   = 1'b0;
    ecc_pkg::field_t result_q = '0;
    logic            pending  = 1'b0;
    logic [3:0]      wait_cnt = '0;

    function automatic ecc_pkg::field_t mulmod(input ecc_pkg::field_t x, input ecc_pkg::field_t y);
        logic [63:0] p;
        p = {32'd0, x} * {32'd0, y};
        return ecc_pkg::field_t'(p % {32'd0, PRIME});
    endfunction

    // b^e by square and multiply
    function automatic ecc_pkg::field_t powmod(input ecc_pkg::field_t b, input ecc_pkg::field_t e);
        ecc_pkg::field_t r;
        ecc_pkg::field_t sq;
        r  = 32'd1;
        sq = b;
        for (int i = 0; i < 32; i++)
        begin
            if (e[i])
                r = mulmod(r, sq);
            sq = mulmod(sq, sq);
        end
        return r;
    endfunction

    function automatic ecc_pkg::field_t compute(input ecc_pkg::field_op_t op,
                                                input ecc_pkg::field_t x,
                                                input ecc_pkg::field_t y);
        logic [32:0] s;
        s = '0;
        case (op)
            ecc_pkg::OP_ADD: s = {1'b0, x} + {1'b0, y};
            ecc_pkg::OP_SUB: s = {1'b0, x} + {1'b0, PRIME} - {1'b0, y};
            ecc_pkg::OP_MUL: return mulmod(x, y);
            default:         return mulmod(x, powmod(y, PRIME - 32'd2));    // Fermat inverse
        endcase
        return (s >= {1'b0, PRIME}) ? ecc_pkg::field_t'(s - {1'b0, PRIME}) : s[31:0];
    endfunction

    always @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            done_q   <= 1'b0;
            pending  <= 1'b0;
            wait_cnt <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (pending)
            begin
                if (wait_cnt <= 4'd1)
                begin
                    done_q   <= 1'b1;
                    result_q <= compute(i_op, i_opnd_a, i_opnd_b);
                    pending  <= 1'b0;
                end
                else
                    wait_cnt <= wait_cnt - 4'd1;
            end
            else if (i_req && !done_q)    // req still high in the done cycle
            begin
                pending  <= 1'b1;
                wait_cnt <= 4'(($random(seed) & 7) + 1);
            end
        end
    end

    assign o_done   = done_q;
    assign o_result = result_q;

endmodule

// File: design/point_mult_top.sv
`timescale 1ns/1ps

module point_mult_top #(
    parameter int FIELD_WIDTH = ecc_pkg::FIELD_WIDTH_DEFAULT,
    parameter int KEY_BITS    = ecc_pkg::KEY_BITS_DEFAULT
) (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic [KEY_BITS-1:0]    i_key,
    input  logic [FIELD_WIDTH-1:0] i_px,
    input  logic [FIELD_WIDTH-1:0] i_py,
    input  logic [FIELD_WIDTH-1:0] i_a,
    output ecc_pkg::field_op_t     o_op,
    output logic [FIELD_WIDTH-1:0] o_opnd_a,
    output logic [FIELD_WIDTH-1:0] o_opnd_b,
    output logic                   o_op_req,
    input  logic                   i_op_done,
    input  logic [FIELD_WIDTH-1:0] i_op_result,
    output logic                   o_busy,
    output logic                   o_done,
    output logic [FIELD_WIDTH-1:0] o_qx,
    output logic [FIELD_WIDTH-1:0] o_qy
);

    ecc_pkg::step_t        step;
    ecc_pkg::operand_sel_t sel_a;
    ecc_pkg::operand_sel_t sel_b;
    ecc_pkg::operand_sel_t dest;
    logic                  load;
    logic                  write;
    logic                  shift;
    logic                  key_bit;
    logic                  key_last;

    key_register #(
        .KEY_BITS (KEY_BITS)
    ) u_key (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_load  (load),
        .i_key   (i_key),
        .i_shift (shift),
        .o_bit   (key_bit),
        .o_last  (key_last)
    );

    point_registers u_regs (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_load   (load),
        .i_px     (i_px),
        .i_py     (i_py),
        .i_a      (i_a),
        .i_sel_a  (sel_a),
        .i_sel_b  (sel_b),
        .i_dest   (dest),
        .i_write  (write),
        .i_result (i_op_result),
        .o_opnd_a (o_opnd_a),
        .o_opnd_b (o_opnd_b),
        .o_qx     (o_qx),
        .o_qy     (o_qy)
    );

    micro_op_table u_table (
        .i_step  (step),
        .o_op    (o_op),    // straight to the field unit
        .o_sel_a (sel_a),
        .o_sel_b (sel_b),
        .o_dest  (dest)
    );

    point_sequencer #(
        .KEY_BITS (KEY_BITS)
    ) u_seq (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (i_start),
        .i_op_done (i_op_done),
        .i_bit     (key_bit),
        .i_last    (key_last),
        .o_step    (step),
        .o_op_req  (o_op_req),
        .o_load    (load),
        .o_write   (write),
        .o_shift   (shift),
        .o_busy    (o_busy),
        .o_done    (o_done)
    );

endmodule

// File: design/point_sequencer.sv
`timescale 1ns/1ps

module point_sequencer #(
    parameter int KEY_BITS = ecc_pkg::KEY_BITS_DEFAULT
) (
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_start,
    input  logic           i_op_done,
    input  logic           i_bit,
    input  logic           i_last,
    output ecc_pkg::step_t o_step,
    output logic           o_op_req,
    output logic           o_load,
    output logic           o_write,
    output logic           o_shift,
    output logic           o_busy,
    output logic           o_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_NEXT_BIT
    } state_t;

    state_t         state;
    state_t         state_n;
    ecc_pkg::step_t step_q;
    ecc_pkg::step_t step_n;
    logic           done_q;

    always_comb
    begin
        state_n = state;
        step_n  = step_q;
        case (state)
            ST_IDLE:
            begin
                if (i_start)
                begin
                    state_n = ST_ISSUE;
                    step_n  = ecc_pkg::DOUBLE_FIRST;
                end
            end
            ST_ISSUE:
                state_n = ST_WAIT;    // request rises next cycle
            ST_WAIT:
            begin
                if (i_op_done)
                begin
                    if (step_q == ecc_pkg::DOUBLE_LAST && i_bit)
                    begin
                        state_n = ST_ISSUE;
                        step_n  = ecc_pkg::ADD_FIRST;
                    end
                    else if (step_q == ecc_pkg::DOUBLE_LAST || step_q == ecc_pkg::ADD_LAST)
                        state_n = ST_NEXT_BIT;
                    else
                    begin
                        state_n = ST_ISSUE;
                        step_n  = step_q + ecc_pkg::step_t'(1);
                    end
                end
            end
            ST_NEXT_BIT:
            begin
                step_n  = ecc_pkg::DOUBLE_FIRST;
                state_n = i_last ? ST_IDLE : ST_ISSUE;
            end
            default:
                state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state  <= ST_IDLE;
            step_q <= ecc_pkg::DOUBLE_FIRST;
            done_q <= 1'b0;
        end
        else
        begin
            state  <= state_n;
            step_q <= step_n;
            done_q <= (state == ST_NEXT_BIT) && i_last;    // busy drops on same edge
        end
    end

    assign o_step   = step_q;
    assign o_op_req = (state == ST_WAIT);
    assign o_load   = (state == ST_IDLE) && i_start;
    assign o_write  = (state == ST_WAIT) && i_op_done;
    assign o_shift  = (state == ST_NEXT_BIT);
    assign o_busy   = (state != ST_IDLE);
    assign o_done   = done_q;

endmodule

// File: design/micro_op_table.sv
`timescale 1ns/1ps

module micro_op_table (
    input  ecc_pkg::step_t        i_step,
    output ecc_pkg::field_op_t    o_op,
    output ecc_pkg::operand_sel_t o_sel_a,
    output ecc_pkg::operand_sel_t o_sel_b,
    output ecc_pkg::operand_sel_t o_dest
);

    localparam int ENTRY_W = $bits(ecc_pkg::field_op_t) + 3 * $bits(ecc_pkg::operand_sel_t);

    logic [ENTRY_W-1:0] e;

    function automatic logic [ENTRY_W-1:0] entry(
        input ecc_pkg::field_op_t    op,
        input ecc_pkg::operand_sel_t sel_a,
        input ecc_pkg::operand_sel_t sel_b,
        input ecc_pkg::operand_sel_t dest
    );
        return {op, sel_a, sel_b, dest};
    endfunction

    always_comb
    begin
        case (i_step)
            // doubling, lambda = (3x^2 + a) / 2y
            5'd0:  e = entry(ecc_pkg::OP_MUL, ecc_pkg::SEL_X,
                             ecc_pkg::SEL_X,  ecc_pkg::SEL_T1);
            5'd1:  e = entry(ecc_pkg::OP_ADD, ecc_pkg::SEL_T1,
                             ecc_pkg::SEL_T1, ecc_pkg::SEL_T2);
            5'd2:  e = entry(ecc_pkg::OP_ADD, ecc_pkg::SEL_T1,
                             ecc_pkg::SEL_T2, ecc_pkg::SEL_T1);    // 3x^2
            5'd3:  e = entry(ecc_pkg::OP_ADD, ecc_pkg::SEL_T1,
                             ecc_pkg::SEL_A,  ecc_pkg::SEL_T1);
            5'd4:  e = entry(ecc_pkg::OP_ADD, ecc_pkg::SEL_Y,
                             ecc_pkg::SEL_Y,  ecc_pkg::SEL_T2);    // 2y
            5'd5:  e = entry(ecc_pkg::OP_DIV, ecc_pkg::SEL_T1,
                             ecc_pkg::SEL_T2, ecc_pkg::SEL_T1);
            5'd6:  e = entry(ecc_pkg::OP_MUL, ecc_pkg::SEL_T1,
                             ecc_pkg::SEL_T1, ecc_pkg::SEL_T2);
            5'd7:  e = entry(ecc_pkg::OP_SUB, ecc_pkg::SEL_T2,
                             ecc_pkg::SEL_X,  ecc_pkg::SEL_T2);
            5'd8:  e = entry(ecc_pkg::OP_SUB, ecc_pkg::SEL_T2,
                             ecc_pkg::SEL_X,  ecc_pkg::SEL_T2_X3);    // x3
            5'd9:  e = entry(ecc_pkg::OP_SUB, ecc_pkg::SEL_X,
                             ecc_pkg::SEL_T2, ecc_pkg::SEL_T2);
            5'd10: e = entry(ecc_pkg::OP_MUL, ecc_pkg::SEL_T1,
                             ecc_pkg::SEL_T2, ecc_pkg::SEL_T1);
            5'd11: e = entry(ecc_pkg::OP_SUB, ecc_pkg::SEL_T1,
                             ecc_pkg::SEL_Y,  ecc_pkg::SEL_Y);
            // addition of the base point
            5'd12: e = entry(ecc_pkg::OP_SUB, ecc_pkg::SEL_BX,
                             ecc_pkg::SEL_X,  ecc_pkg::SEL_T1);
            5'd13: e = entry(ecc_pkg::OP_SUB, ecc_pkg::SEL_BY,
                             ecc_pkg::SEL_Y,  ecc_pkg::SEL_T2);
            5'd14: e = entry(ecc_pkg::OP_DIV, ecc_pkg::SEL_T2,
                             ecc_pkg::SEL_T1, ecc_pkg::SEL_T1);    // lambda
            5'd15: e = entry(ecc_pkg::OP_MUL, ecc_pkg::SEL_T1,
                             ecc_pkg::SEL_T1, ecc_pkg::SEL_T2);
            5'd16: e = entry(ecc_pkg::OP_SUB, ecc_pkg::SEL_T2,
                             ecc_pkg::SEL_X,  ecc_pkg::SEL_T2);
            5'd17: e = entry(ecc_pkg::OP_SUB, ecc_pkg::SEL_T2,
                             ecc_pkg::SEL_BX, ecc_pkg::SEL_T2_X3);
            5'd18: e = entry(ecc_pkg::OP_SUB, ecc_pkg::SEL_X,
                             ecc_pkg::SEL_T2, ecc_pkg::SEL_T2);
            5'd19: e = entry(ecc_pkg::OP_MUL, ecc_pkg::SEL_T1,
                             ecc_pkg::SEL_T2, ecc_pkg::SEL_T2);
            5'd20: e = entry(ecc_pkg::OP_SUB, ecc_pkg::SEL_T2,
                             ecc_pkg::SEL_Y,  ecc_pkg::SEL_Y);
            default: e = '0;
        endcase
    end

    assign {o_op, o_sel_a, o_sel_b, o_dest} = e;

endmodule

// File: design/point_registers.sv
`timescale 1ns/1ps

module point_registers (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_load,
    input  ecc_pkg::field_t       i_px,
    input  ecc_pkg::field_t       i_py,
    input  ecc_pkg::field_t       i_a,
    input  ecc_pkg::operand_sel_t i_sel_a,
    input  ecc_pkg::operand_sel_t i_sel_b,
    input  ecc_pkg::operand_sel_t i_dest,
    input  logic                  i_write,
    input  ecc_pkg::field_t       i_result,
    output ecc_pkg::field_t       o_opnd_a,
    output ecc_pkg::field_t       o_opnd_b,
    output ecc_pkg::field_t       o_qx,
    output ecc_pkg::field_t       o_qy
);

    ecc_pkg::field_t acc_x;
    ecc_pkg::field_t acc_y;
    ecc_pkg::field_t base_x;
    ecc_pkg::field_t base_y;
    ecc_pkg::field_t coef_a;
    ecc_pkg::field_t tmp1;
    ecc_pkg::field_t tmp2;
    ecc_pkg::field_t x3;    // new x, held until y is ready

    function automatic ecc_pkg::field_t pick(input ecc_pkg::operand_sel_t sel);
        case (sel)
            ecc_pkg::SEL_X:  return acc_x;
            ecc_pkg::SEL_Y:  return acc_y;
            ecc_pkg::SEL_BX: return base_x;
            ecc_pkg::SEL_BY: return base_y;
            ecc_pkg::SEL_T1: return tmp1;
            ecc_pkg::SEL_T2: return tmp2;
            ecc_pkg::SEL_A:  return coef_a;
            default:         return '0;
        endcase
    endfunction

    always_comb
    begin
        o_opnd_a = pick(i_sel_a);
        o_opnd_b = pick(i_sel_b);
    end

    // accumulator, x and y change together at the last step
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            acc_x <= '0;
            acc_y <= '0;
        end
        else if (i_load)
        begin
            acc_x <= i_px;
            acc_y <= i_py;
        end
        else if (i_write)
        begin
            if (i_dest == ecc_pkg::SEL_X)
                acc_x <= i_result;
            if (i_dest == ecc_pkg::SEL_Y)
            begin
                acc_x <= x3;
                acc_y <= i_result;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            base_x <= i_px;
            base_y <= i_py;
            coef_a <= i_a;
        end
        else if (i_write)
        begin
            case (i_dest)
                ecc_pkg::SEL_BX: base_x <= i_result;
                ecc_pkg::SEL_BY: base_y <= i_result;
                ecc_pkg::SEL_T1: tmp1   <= i_result;
                ecc_pkg::SEL_T2: tmp2   <= i_result;
                ecc_pkg::SEL_A:  coef_a <= i_result;
                ecc_pkg::SEL_T2_X3:
                begin
                    tmp2 <= i_result;
                    x3   <= i_result;
                end
                default: ;    // x and y handled above
            endcase
        end
    end

    assign o_qx = acc_x;
    assign o_qy = acc_y;

endmodule

// File: design/key_register.sv
`timescale 1ns/1ps

module key_register #(
    parameter int KEY_BITS = ecc_pkg::KEY_BITS_DEFAULT
) (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_load,
    input  logic [KEY_BITS-1:0] i_key,
    input  logic                i_shift,
    output logic                o_bit,
    output logic                o_last
);

    localparam int CNT_W = $clog2(KEY_BITS + 1);

    logic [KEY_BITS-1:0] key_q;
    logic [CNT_W-1:0]    shift_cnt;

    always_ff @(posedge i_clk)
    begin
        if (i_load)
            key_q <= i_key;
        else if (i_shift)
            key_q <= key_q << 1;    // msb first
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
            shift_cnt <= '0;
        else if (i_load)
            shift_cnt <= '0;
        else if (i_shift)
            shift_cnt <= shift_cnt + 1'b1;
    end

    assign o_bit  = key_q[KEY_BITS-1];
    assign o_last = (shift_cnt == CNT_W'(KEY_BITS - 1));    // final bit is current

endmodule

// File: design/ecc_pkg.sv
package ecc_pkg;

    localparam int FIELD_WIDTH_DEFAULT = 32;
    localparam int KEY_BITS_DEFAULT    = 16;

    typedef logic [FIELD_WIDTH_DEFAULT-1:0] field_t;
    typedef logic [1:0]                     field_op_t;
    typedef logic [2:0]                     operand_sel_t;
    typedef logic [4:0]                     step_t;

    // field unit operation codes
    localparam field_op_t OP_ADD = 2'd0;
    localparam field_op_t OP_SUB = 2'd1;
    localparam field_op_t OP_MUL = 2'd2;
    localparam field_op_t OP_DIV = 2'd3;

    // working registers, shared by operand selects and destinations
    localparam operand_sel_t SEL_X     = 3'd0;    // accumulator x
    localparam operand_sel_t SEL_Y     = 3'd1;    // accumulator y
    localparam operand_sel_t SEL_BX    = 3'd2;    // base point x
    localparam operand_sel_t SEL_BY    = 3'd3;    // base point y
    localparam operand_sel_t SEL_T1    = 3'd4;
    localparam operand_sel_t SEL_T2    = 3'd5;
    localparam operand_sel_t SEL_A     = 3'd6;    // curve coefficient
    localparam operand_sel_t SEL_T2_X3 = 3'd7;    // dest only: T2 and deferred x

    // doubling runs 0..11, addition 12..20
    localparam step_t DOUBLE_FIRST = 5'd0;
    localparam step_t DOUBLE_LAST  = 5'd11;
    localparam step_t ADD_FIRST    = 5'd12;
    localparam step_t ADD_LAST     = 5'd20;

endpackage
